//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_pkt_scoreboard
RTL_TOP    ?= pkt_scoreboard_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
RTL_FILES  ?= hdl/scb_pkg.sv hdl/netfifo.sv hdl/stream_compare.sv \
              hdl/wb_status_regs.sv hdl/pkt_scoreboard_top.sv
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/scoreboard_properties.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_properties (
		input	logic				S_AXI_ACLK,
		input	logic				S_AXI_ARESETN,
		// compare engine handshake, tied low where not bound to it
		input	logic				model_valid,
		input	logic				model_ready,
		input	logic				model_last,
		input	logic				dut_valid,
		input	logic				dut_ready,
		input	logic				dut_last,
		input	logic				drain,
		input	logic				clear,
		input	logic	[scb_pkg::CNT_W-1:0]	matched_cnt,
		input	logic	[scb_pkg::CNT_W-1:0]	mismatched_cnt,
		// wishbone ack, tied low where not bound to the slave
		input	logic				wb_ack
	);

	// failed property count
	int	failures = 0;

	logic	model_take;
	logic	dut_take;
	logic	last_take;

	assign model_take = model_valid && model_ready;
	assign dut_take   = dut_valid && dut_ready;
	// a packet end left one of the FIFOs this cycle
	assign last_take  = (model_take && model_last) || (dut_take && dut_last);

	//////////////////////////////////////////////////////////////////////
	// handshake and bus rules
	//////////////////////////////////////////////////////////////////////

	// outside drain mode beats only move as a pair
	pair_taken: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(!drain && (model_take || dut_take)) |-> (model_take && dut_take))
	else
	begin
		failures++;
		$error("beat consumed on one side only outside drain mode");
	end

	// one ack cycle per access
	single_ack: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wb_ack |=> !wb_ack)
	else
	begin
		failures++;
		$error("wishbone ack held for two cycles");
	end

	// counters move only on a consumed last beat or a clear pulse
	count_cause: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		($changed(matched_cnt) || $changed(mismatched_cnt)) |-> $past(clear || last_take))
	else
	begin
		failures++;
		$error("packet counter changed without a last beat or clear");
	end

endmodule

`default_nettype wire

//--- bench/tb_pkt_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_scoreboard;

	import scb_pkg::*;

	// kinds of packet pair, model copy vs DUT copy
	localparam int K_CLEAN = 0;
	localparam int K_FLIP  = 1;
	localparam int K_PAD   = 2;
	localparam int K_BYTES = 3;
	localparam int K_ABORT = 4;
	localparam int K_SHORT = 5;
	localparam int K_LONG  = 6;

	localparam int N_FIRST  = 8;
	localparam int N_SECOND = 32;
	// every kind once at the start of the second phase
	localparam int FIXED_KINDS [0:7] = '{K_FLIP, K_PAD, K_BYTES, K_ABORT,
		K_SHORT, K_CLEAN, K_LONG, K_CLEAN};
	// packets x beats x cycles per beat, plus slack for bus polling
	localparam int TIMEOUT_CYCLES = (N_FIRST + N_SECOND) * 8 * 4 + 2000;

	logic			S_AXI_ACLK = 1'b0;
	logic			S_AXI_ARESETN;
	logic			model_valid;
	logic			model_ready;
	axin_beat_t		model_beat;
	logic			dut_valid;
	logic			dut_ready;
	axin_beat_t		dut_beat;
	logic			wb_cyc;
	logic			wb_stb;
	logic			wb_we;
	logic	[WB_AW-1:0]	wb_adr;
	logic	[WB_DW-1:0]	wb_dat_w;
	logic			wb_ack;
	logic	[WB_DW-1:0]	wb_dat_r;

	logic	[31:0]		lfsr;
	int			errors;
	int			checks;
	int			cycles;
	int			access_cnt;
	int			ack_cnt;
	// pending beats and the idle cycles before each, per side
	axin_beat_t		model_q[$];
	axin_beat_t		dut_q[$];
	int			model_gap_q[$];
	int			dut_gap_q[$];
	int			kinds_q[$];

	pkt_scoreboard_top #(
		.LGFLEN(6)
	) uut (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.model_valid(model_valid),
		.model_ready(model_ready),
		.model_beat(model_beat),
		.dut_valid(dut_valid),
		.dut_ready(dut_ready),
		.dut_beat(dut_beat),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r)
	);

	bind stream_compare scoreboard_properties u_props (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.model_valid(model_valid),
		.model_ready(model_ready),
		.model_last(model_beat.last),
		.dut_valid(dut_valid),
		.dut_ready(dut_ready),
		.dut_last(dut_beat.last),
		.drain(drain),
		.clear(clear),
		.matched_cnt(matched_cnt),
		.mismatched_cnt(mismatched_cnt),
		.wb_ack(1'b0)
	);

	bind wb_status_regs scoreboard_properties u_props (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.model_valid(1'b0),
		.model_ready(1'b0),
		.model_last(1'b0),
		.dut_valid(1'b0),
		.dut_ready(1'b0),
		.dut_last(1'b0),
		.drain(1'b0),
		.clear(clear),
		.matched_cnt('0),
		.mismatched_cnt('0),
		.wb_ack(wb_ack)
	);

	//////////////////////////////////////////////////////////////////////
	// clock, cycle limit, ack count
	//////////////////////////////////////////////////////////////////////

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK)
	begin
		cycles++;
		if (wb_ack)
			ack_cnt++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("checks %0d errors %0d", checks, errors + 1);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic	[31:0]	v;
		logic		fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// expected counts from the packet kinds alone
	function automatic void expected_counts(input int kinds[$], output int n_match,
		output int n_mismatch);
		n_match    = 0;
		n_mismatch = 0;
		foreach (kinds[i])
		begin
			// pad bytes are masked, an aborted copy never reaches the compare
			if (kinds[i] == K_CLEAN || kinds[i] == K_PAD || kinds[i] == K_ABORT)
				n_match++;
			else
				n_mismatch++;
		end
	endfunction

	task automatic push_beat(input bit dut_side, input axin_beat_t b);
		int gap;
		gap = int'(take_bits(2));
		if (dut_side)
		begin
			dut_q.push_back(b);
			dut_gap_q.push_back(gap);
		end
		else
		begin
			model_q.push_back(b);
			model_gap_q.push_back(gap);
		end
	endtask

	// model copy first, then the DUT copy altered by kind
	task automatic build_packet(input int kind);
		axin_beat_t	pkt[$];
		axin_beat_t	b;
		int		len;
		int		idx;
		logic	[2:0]	nbytes;
		len = 1 + int'(take_bits(3));
		if (kind == K_SHORT && len == 1)
			len = 2;
		nbytes = 3'(take_bits(3));
		// byte 7 has to lie outside the bytes field
		if (kind == K_PAD && nbytes == 3'd0)
			nbytes = 3'd5;
		for (int i = 0; i < len; i++)
		begin
			b.data  = {take_bits(32), take_bits(32)};
			b.bytes = nbytes;
			b.last  = (i == len - 1);
			b.abort = 1'b0;
			pkt.push_back(b);
			push_beat(1'b0, b);
		end
		case (kind)
			K_FLIP:
			begin
				// low byte is always inside the compared bytes
				idx = int'(take_bits(3)) % len;
				b = pkt[idx];
				b.data = b.data ^ (64'd1 << take_bits(3));
				pkt[idx] = b;
			end
			K_PAD:
			begin
				b = pkt[len-1];
				b.data = b.data ^ (64'd1 << (56 + int'(take_bits(3))));
				pkt[len-1] = b;
			end
			K_BYTES:
			begin
				b = pkt[len-1];
				b.bytes = nbytes + 3'd1;
				pkt[len-1] = b;
			end
			K_SHORT:
			begin
				void'(pkt.pop_back());
				b = pkt[len-2];
				b.last = 1'b1;
				pkt[len-2] = b;
			end
			K_LONG:
			begin
				b = pkt[len-1];
				b.last = 1'b0;
				pkt[len-1] = b;
				b.data = {take_bits(32), take_bits(32)};
				b.last = 1'b1;
				pkt.push_back(b);
			end
			K_ABORT:
			begin
				// partial copy, abort flag on its final beat
				idx = 1 + int'(take_bits(3)) % len;
				for (int i = 0; i < idx; i++)
				begin
					b = pkt[i];
					b.abort = (i == idx - 1);
					push_beat(1'b1, b);
				end
			end
			default:
			begin
			end
		endcase
		foreach (pkt[i])
			push_beat(1'b1, pkt[i]);
		kinds_q.push_back(kind);
	endtask

	// one stream driver, holds the beat until ready
	task automatic drive_side(input bit dut_side);
		axin_beat_t	b;
		int		gap;
		logic		accepted;
		while ((dut_side ? dut_q.size() : model_q.size()) > 0)
		begin
			if (dut_side)
			begin
				b   = dut_q.pop_front();
				gap = dut_gap_q.pop_front();
			end
			else
			begin
				b   = model_q.pop_front();
				gap = model_gap_q.pop_front();
			end
			repeat (gap)
			begin
				@(posedge S_AXI_ACLK);
				#1;
			end
			if (dut_side)
			begin
				dut_valid = 1'b1;
				dut_beat  = b;
			end
			else
			begin
				model_valid = 1'b1;
				model_beat  = b;
			end
			// FIFO ready is registered, steady up to the next edge
			do
			begin
				accepted = dut_side ? dut_ready : model_ready;
				@(posedge S_AXI_ACLK);
				#1;
			end
			while (!accepted);
			if (dut_side)
				dut_valid = 1'b0;
			else
				model_valid = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// wishbone master and checks
	//////////////////////////////////////////////////////////////////////

	task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
		input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rdat);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		access_cnt++;
		waited = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			#1;
			waited++;
		end
		while (!wb_ack && waited < 16);
		checks++;
		assert (wb_ack)
		else
		begin
			$display("no ack for wishbone access to register %0d", adr);
			errors++;
		end
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge S_AXI_ACLK);
		#1;
		checks++;
		assert (!wb_ack)
		else
		begin
			$display("wishbone ack still high after the master ended the cycle");
			errors++;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// poll until every packet of the phase has been scored
	task automatic wait_for_counts(input int total);
		logic	[WB_DW-1:0]	m;
		logic	[WB_DW-1:0]	mm;
		do
		begin
			wb_access(1'b0, REG_MATCHED, 32'd0, m);
			wb_access(1'b0, REG_MISMATCHED, 32'd0, mm);
		end
		while (int'(m) + int'(mm) < total);
	endtask

	task automatic check_counts(input int exp_match, input int exp_mism);
		logic	[WB_DW-1:0]	rd;
		logic			pass_exp;
		pass_exp = (exp_mism == 0) && (exp_match != 0);
		wb_access(1'b0, REG_MATCHED, 32'd0, rd);
		check_value("matched_cnt", rd, 32'(exp_match));
		wb_access(1'b0, REG_MISMATCHED, 32'd0, rd);
		check_value("mismatched_cnt", rd, 32'(exp_mism));
		// idle expected, every phase ends on a clean pair
		wb_access(1'b0, REG_STATUS, 32'd0, rd);
		check_value("status", rd, {30'd0, 1'b1, pass_exp});
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic	[WB_DW-1:0]	rd;
		int			exp_match;
		int			exp_mism;
		int			kind;
		int			prop_fail;
		S_AXI_ARESETN = 1'b0;
		model_valid   = 1'b0;
		model_beat    = '0;
		dut_valid     = 1'b0;
		dut_beat      = '0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_w      = '0;
		lfsr          = 32'h4667_084c;
		repeat (5) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// identical copies, independent gaps
		for (int i = 0; i < N_FIRST; i++)
			build_packet(K_CLEAN);
		fork
			drive_side(1'b0);
			drive_side(1'b1);
		join
		expected_counts(kinds_q, exp_match, exp_mism);
		wait_for_counts(exp_match + exp_mism);
		check_counts(exp_match, exp_mism);

		// counter clear through the control register
		wb_access(1'b1, REG_CONTROL, 32'd1, rd);
		check_counts(0, 0);

		// corrupted, aborted, short and long copies
		kinds_q.delete();
		foreach (FIXED_KINDS[i])
			build_packet(FIXED_KINDS[i]);
		kind = K_CLEAN;
		for (int i = 0; i < N_SECOND - 9; i++)
		begin
			// a length mismatch is followed by a clean pair
			if (kind == K_SHORT || kind == K_LONG)
				kind = K_CLEAN;
			else
				kind = int'(take_bits(3));
			if (kind > K_LONG)
				kind = K_CLEAN;
			build_packet(kind);
		end
		build_packet(K_CLEAN);
		fork
			drive_side(1'b0);
			drive_side(1'b1);
		join
		expected_counts(kinds_q, exp_match, exp_mism);
		wait_for_counts(exp_match + exp_mism);
		check_counts(exp_match, exp_mism);

		check_value("ack_cnt", 32'(ack_cnt), 32'(access_cnt));
		prop_fail = uut.u_compare.u_props.failures + uut.u_regs.u_props.failures;
		checks++;
		assert (prop_fail == 0)
		else
		begin
			$display("bound property checks failed %0d times", prop_fail);
			errors++;
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hdl/scb_pkg.sv
hdl/netfifo.sv
hdl/stream_compare.sv
hdl/wb_status_regs.sv
hdl/pkt_scoreboard_top.sv
bench/scoreboard_properties.sv
bench/tb_pkt_scoreboard.sv

//--- hdl/netfifo.sv
`timescale 1ns/1ps
`default_nettype none

module netfifo #(
		parameter int LGFLEN = 6
	) (
		input	logic			S_AXI_ACLK,
		input	logic			S_AXI_ARESETN,
		// write side where packets may be aborted
		input	logic			in_valid,
		output	logic			in_ready,
		input	scb_pkg::axin_beat_t	in_beat,
		// read side sees committed packets only
		output	logic			out_valid,
		input	logic			out_ready,
		output	scb_pkg::axin_beat_t	out_beat
	);

	import scb_pkg::*;

	localparam int DEPTH = 1 << LGFLEN;

	// beat storage
	axin_beat_t		mem [0:DEPTH-1];

	// pointers carry one extra wrap bit
	logic	[LGFLEN:0]	wr_ptr;
	logic	[LGFLEN:0]	commit_ptr;
	logic	[LGFLEN:0]	rd_ptr;
	// beats held whether committed or not
	logic	[LGFLEN:0]	fill;

	logic			wr_en;
	logic			rd_en;
	axin_beat_t		rd_beat;

	//////////////////////////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////////////////////////

	assign fill     = wr_ptr - rd_ptr;
	// top bit of fill set only when every slot is taken
	assign in_ready = !fill[LGFLEN];
	assign wr_en    = in_valid && in_ready;

	// abort beats are never stored
	always_ff @(posedge S_AXI_ACLK)
	if (wr_en && !in_beat.abort)
		mem[wr_ptr[LGFLEN-1:0]] <= in_beat;

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		wr_ptr     <= '0;
		commit_ptr <= '0;
	end
	else if (wr_en)
	begin
		if (in_beat.abort)
			// drop everything since the last commit including this beat
			wr_ptr <= commit_ptr;
		else
		begin
			wr_ptr <= wr_ptr + 1'b1;
			// packet complete so release it to the reader
			if (in_beat.last)
				commit_ptr <= wr_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////////////////////////

	// only beats below the commit pointer are visible
	assign out_valid = (rd_ptr != commit_ptr);
	assign rd_en     = out_valid && out_ready;

	// combinational read from the read pointer
	assign rd_beat = mem[rd_ptr[LGFLEN-1:0]];

	assign out_beat.data  = rd_beat.data;
	assign out_beat.bytes = rd_beat.bytes;
	assign out_beat.last  = rd_beat.last;
	// aborted beats never leave the FIFO
	assign out_beat.abort = 1'b0;

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		rd_ptr <= '0;
	else if (rd_en)
		rd_ptr <= rd_ptr + 1'b1;

endmodule

`default_nettype wire

//--- hdl/pkt_scoreboard_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_scoreboard_top #(
		parameter int LGFLEN = 6
	) (
		input	logic				S_AXI_ACLK,
		input	logic				S_AXI_ARESETN,
		// model stream
		input	logic				model_valid,
		output	logic				model_ready,
		input	scb_pkg::axin_beat_t		model_beat,
		// stream from the unit under test
		input	logic				dut_valid,
		output	logic				dut_ready,
		input	scb_pkg::axin_beat_t		dut_beat,
		// wishbone host port
		input	logic				wb_cyc,
		input	logic				wb_stb,
		input	logic				wb_we,
		input	logic	[scb_pkg::WB_AW-1:0]	wb_adr,
		input	logic	[scb_pkg::WB_DW-1:0]	wb_dat_w,
		output	logic				wb_ack,
		output	logic	[scb_pkg::WB_DW-1:0]	wb_dat_r
	);

	import scb_pkg::*;

	// FIFO outputs toward the compare engine
	logic			mf_valid;
	logic			mf_ready;
	axin_beat_t		mf_beat;
	logic			df_valid;
	logic			df_ready;
	axin_beat_t		df_beat;

	// compare engine and register slave
	logic	[CNT_W-1:0]	matched_cnt;
	logic	[CNT_W-1:0]	mismatched_cnt;
	logic			idle;
	logic			clear;

	//////////////////////////////////////////////////////////////////////
	// packet FIFOs, one per stream
	//////////////////////////////////////////////////////////////////////

	netfifo #(
		.LGFLEN(LGFLEN)
	) u_model_fifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.in_valid(model_valid),
		.in_ready(model_ready),
		.in_beat(model_beat),
		.out_valid(mf_valid),
		.out_ready(mf_ready),
		.out_beat(mf_beat)
	);

	netfifo #(
		.LGFLEN(LGFLEN)
	) u_dut_fifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.in_valid(dut_valid),
		.in_ready(dut_ready),
		.in_beat(dut_beat),
		.out_valid(df_valid),
		.out_ready(df_ready),
		.out_beat(df_beat)
	);

	//////////////////////////////////////////////////////////////////////
	// compare engine and status registers
	//////////////////////////////////////////////////////////////////////

	stream_compare u_compare (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.model_valid(mf_valid),
		.model_ready(mf_ready),
		.model_beat(mf_beat),
		.dut_valid(df_valid),
		.dut_ready(df_ready),
		.dut_beat(df_beat),
		.clear(clear),
		.matched_cnt(matched_cnt),
		.mismatched_cnt(mismatched_cnt),
		.idle(idle)
	);

	wb_status_regs u_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.matched_cnt(matched_cnt),
		.mismatched_cnt(mismatched_cnt),
		.idle(idle),
		.clear(clear)
	);

endmodule

`default_nettype wire

//--- hdl/scb_pkg.sv
`default_nettype none

package scb_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	// payload width of one stream beat
	localparam int DATA_W = 64;
	// matched and mismatched packet counters
	localparam int CNT_W  = 16;
	// wishbone word address and data
	localparam int WB_AW  = 2;
	localparam int WB_DW  = 32;

	//////////////////////////////////////////////////////////////////////
	// stream beat
	//////////////////////////////////////////////////////////////////////

	// one beat, valid and ready travel beside it
	// bytes counts valid bytes on a last beat, 0 means all eight
	typedef struct packed {
		logic	[DATA_W-1:0]	data;
		logic	[2:0]		bytes;
		logic			last;
		logic			abort;
	} axin_beat_t;

	//////////////////////////////////////////////////////////////////////
	// register map (word addresses)
	//////////////////////////////////////////////////////////////////////

	// bit 0 pass, bit 1 idle
	localparam logic [WB_AW-1:0] REG_STATUS     = 2'd0;
	localparam logic [WB_AW-1:0] REG_MATCHED    = 2'd1;
	localparam logic [WB_AW-1:0] REG_MISMATCHED = 2'd2;
	// write 1 to bit 0 clears both counters
	localparam logic [WB_AW-1:0] REG_CONTROL    = 2'd3;

endpackage

`default_nettype wire

//--- hdl/stream_compare.sv
`timescale 1ns/1ps
`default_nettype none

module stream_compare (
		input	logic				S_AXI_ACLK,
		input	logic				S_AXI_ARESETN,
		// model side, from its packet FIFO
		input	logic				model_valid,
		output	logic				model_ready,
		input	scb_pkg::axin_beat_t		model_beat,
		// unit under test side, from its packet FIFO
		input	logic				dut_valid,
		output	logic				dut_ready,
		input	scb_pkg::axin_beat_t		dut_beat,
		// one-cycle pulse from the register slave
		input	logic				clear,
		output	logic	[scb_pkg::CNT_W-1:0]	matched_cnt,
		output	logic	[scb_pkg::CNT_W-1:0]	mismatched_cnt,
		output	logic				idle
	);

	import scb_pkg::*;

	// drain mode skips the rest of the longer packet
	logic			drain;
	// side being drained, 1 means the DUT side
	logic			drain_dut;
	// inside a packet in normal mode
	logic			in_pkt;
	// sticky difference within the current packet
	logic			bad;

	logic			pair;
	logic			both_last;
	logic			one_last;
	logic	[DATA_W-1:0]	keep_mask;
	logic			beat_diff;
	logic			drain_done;

	//////////////////////////////////////////////////////////////////////
	// handshake
	//////////////////////////////////////////////////////////////////////

	// normal mode takes a pair only when both sides have a beat
	assign pair = !drain && model_valid && dut_valid;

	// drain mode takes only the longer side
	assign model_ready = pair || (drain && !drain_dut);
	assign dut_ready   = pair || (drain && drain_dut);

	assign both_last = model_beat.last && dut_beat.last;
	assign one_last  = model_beat.last ^ dut_beat.last;

	// drained side has handed over its last beat
	assign drain_done = drain
		&& (drain_dut ? (dut_valid && dut_beat.last)
			: (model_valid && model_beat.last));

	//////////////////////////////////////////////////////////////////////
	// beat comparison
	//////////////////////////////////////////////////////////////////////

	// keep only the low bytes named by the bytes field on a last beat
	always_comb
	begin
		for (int i = 0; i < DATA_W / 8; i++)
			keep_mask[i*8 +: 8] = (!model_beat.last || model_beat.bytes == 3'd0
				|| i < int'(model_beat.bytes)) ? 8'hff : 8'h00;
	end

	// bytes fields only matter when both sides end here
	assign beat_diff = (((model_beat.data ^ dut_beat.data) & keep_mask) != '0)
		|| (both_last && (model_beat.bytes != dut_beat.bytes));

	//////////////////////////////////////////////////////////////////////
	// packet state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		drain     <= 1'b0;
		drain_dut <= 1'b0;
		in_pkt    <= 1'b0;
		bad       <= 1'b0;
	end
	else if (drain)
	begin
		// resynchronised once the longer packet is gone
		if (drain_done)
			drain <= 1'b0;
	end
	else if (pair)
	begin
		if (both_last)
		begin
			in_pkt <= 1'b0;
			bad    <= 1'b0;
		end
		else if (one_last)
		begin
			// the side without last is the longer one
			drain     <= 1'b1;
			drain_dut <= model_beat.last;
			in_pkt    <= 1'b0;
			bad       <= 1'b0;
		end
		else
		begin
			in_pkt <= 1'b1;
			bad    <= bad || beat_diff;
		end
	end

	assign idle = !drain && !in_pkt;

	//////////////////////////////////////////////////////////////////////
	// packet counters
	//////////////////////////////////////////////////////////////////////

	// length mismatch always counts against the packet
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		matched_cnt    <= '0;
		mismatched_cnt <= '0;
	end
	else if (clear)
	begin
		matched_cnt    <= '0;
		mismatched_cnt <= '0;
	end
	else if (pair && (model_beat.last || dut_beat.last))
	begin
		if (both_last && !bad && !beat_diff)
			matched_cnt <= matched_cnt + 1'b1;
		else
			mismatched_cnt <= mismatched_cnt + 1'b1;
	end

endmodule

`default_nettype wire

//--- hdl/wb_status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_status_regs (
		input	logic				S_AXI_ACLK,
		input	logic				S_AXI_ARESETN,
		// wishbone classic slave
		input	logic				wb_cyc,
		input	logic				wb_stb,
		input	logic				wb_we,
		input	logic	[scb_pkg::WB_AW-1:0]	wb_adr,
		input	logic	[scb_pkg::WB_DW-1:0]	wb_dat_w,
		output	logic				wb_ack,
		output	logic	[scb_pkg::WB_DW-1:0]	wb_dat_r,
		// status from the compare engine
		input	logic	[scb_pkg::CNT_W-1:0]	matched_cnt,
		input	logic	[scb_pkg::CNT_W-1:0]	mismatched_cnt,
		input	logic				idle,
		// counter clear, one cycle wide
		output	logic				clear
	);

	import scb_pkg::*;

	// new access seen, ack not yet given
	logic			wb_req;
	logic			pass;
	logic	[WB_DW-1:0]	rd_word;

	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	// at least one packet and no mismatches
	assign pass = (mismatched_cnt == '0) && (matched_cnt != '0);

	//////////////////////////////////////////////////////////////////////
	// read decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		rd_word = '0;
		case (wb_adr)
			REG_STATUS:
			begin
				rd_word[0] = pass;
				rd_word[1] = idle;
			end
			REG_MATCHED:    rd_word[CNT_W-1:0] = matched_cnt;
			REG_MISMATCHED: rd_word[CNT_W-1:0] = mismatched_cnt;
			// control reads back as zero
			default:        rd_word = '0;
		endcase
	end

	// sampled on the edge that raises ack
	always_ff @(posedge S_AXI_ACLK)
	if (wb_req && !wb_we)
		wb_dat_r <= rd_word;

	//////////////////////////////////////////////////////////////////////
	// ack and clear
	//////////////////////////////////////////////////////////////////////

	// single ack per access, master drops stb after it
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		wb_ack <= 1'b0;
	else
		wb_ack <= wb_req;

	// pulse lines up with ack, counters clear on the next edge
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		clear <= 1'b0;
	else
		clear <= wb_req && wb_we && (wb_adr == REG_CONTROL) && wb_dat_w[0];

endmodule

`default_nettype wire
